// ==== hdl/soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// ------------------------------
// Serial timing
// ------------------------------

// clk_i cycles per serial bit
// An even value of 4 or more works
`define SOC_CLKS_PER_BIT 16

// ------------------------------
// Echo buffer
// ------------------------------

// Depth is 2**SOC_FIFO_DEPTH_LOG2 entries
`define SOC_FIFO_DEPTH_LOG2 3

`endif

// ==== hdl/uart_pkg.sv ====
`include "soc_cfg.svh"

package uart_pkg;

   typedef logic [7:0] uart_byte_t;                             // One serial character
   typedef logic [$clog2(`SOC_CLKS_PER_BIT)-1:0] bit_timer_t;  // Counts one bit period
   typedef logic [2:0] bit_idx_t;                               // Data bit 0..7

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

// ==== hdl/fifo_pkg.sv ====
`include "soc_cfg.svh"

package fifo_pkg;

   // Read or write slot index that wraps at the depth
   typedef logic [`SOC_FIFO_DEPTH_LOG2-1:0] fifo_ptr_t;

   // One extra bit so a full buffer is distinct from an empty one
   typedef logic [`SOC_FIFO_DEPTH_LOG2:0] fifo_cnt_t;

endpackage

// ==== hdl/reset_sync.sv ====
module reset_sync (
   input  logic clk_i,
   input  logic rst_n_i,       // Board reset
   input  logic pll_locked_i,
   output logic rst_n_o
);

   logic       arst_n;
   logic [1:0] sync_q;

   // Either source pulls the internal reset low at once
   assign arst_n = rst_n_i & pll_locked_i;

   // Release goes through two flops
   always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], 1'b1};
      end
   end

   assign rst_n_o = sync_q[1];

endmodule

// ==== hdl/uart_rx.sv ====
`include "soc_cfg.svh"

module uart_rx
   import uart_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       rxd_i,
   output uart_byte_t data_o,
   output logic       valid_o,
   output logic       frame_err_o
);

   localparam bit_timer_t BIT_LAST  = bit_timer_t'(`SOC_CLKS_PER_BIT - 1);
   localparam bit_timer_t HALF_LAST = bit_timer_t'(`SOC_CLKS_PER_BIT / 2 - 1);

   logic       rxd_meta_q;
   logic       rxd_sync_q;
   rx_state_t  state_q;
   bit_timer_t timer_q;
   bit_idx_t   idx_q;
   uart_byte_t shift_q;

   // ------------------------------
   // Input synchronizer
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rxd_meta_q <= 1'b1;   // Line idles high
         rxd_sync_q <= 1'b1;
      end else begin
         rxd_meta_q <= rxd_i;
         rxd_sync_q <= rxd_meta_q;
      end
   end

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= RX_IDLE;
         timer_q     <= '0;
         idx_q       <= '0;
         valid_o     <= 1'b0;
         frame_err_o <= 1'b0;
      end else begin
         valid_o     <= 1'b0;
         frame_err_o <= 1'b0;
         timer_q     <= timer_q + 1'b1;
         case (state_q)
            RX_IDLE: begin
               timer_q <= '0;
               if (!rxd_sync_q) state_q <= RX_START;   // Falling edge
            end
            RX_START: begin
               if (timer_q == HALF_LAST) begin
                  timer_q <= '0;
                  idx_q   <= '0;
                  // High again at mid-bit means a glitch
                  state_q <= rxd_sync_q ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (timer_q == BIT_LAST) begin
                  timer_q <= '0;
                  idx_q   <= idx_q + 1'b1;
                  if (idx_q == 3'd7) state_q <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (timer_q == BIT_LAST) begin
                  valid_o     <= rxd_sync_q;
                  frame_err_o <= !rxd_sync_q;   // Low stop bit
                  state_q     <= RX_IDLE;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk_i) begin
      if (state_q == RX_DATA && timer_q == BIT_LAST) begin
         shift_q <= {rxd_sync_q, shift_q[7:1]};
      end
   end

   assign data_o = shift_q;

   a_one_strobe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(valid_o && frame_err_o));

endmodule

// ==== hdl/byte_fifo.sv ====
`include "soc_cfg.svh"

module byte_fifo
   import uart_pkg::*;
   import fifo_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       push_i,
   input  uart_byte_t data_i,
   input  logic       pop_i,
   output uart_byte_t data_o,
   output logic       empty_o,
   output logic       ovf_o
);

   localparam int DEPTH = 1 << `SOC_FIFO_DEPTH_LOG2;

   uart_byte_t mem_q [DEPTH];
   fifo_ptr_t  wr_ptr_q;
   fifo_ptr_t  rd_ptr_q;
   fifo_cnt_t  count_q;
   logic       full;
   logic       do_push;

   assign full    = (count_q == fifo_cnt_t'(DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i & (~full | pop_i);   // Pop frees a slot this cycle
   assign ovf_o   = push_i & full & ~pop_i;     // Byte dropped
   assign data_o  = mem_q[rd_ptr_q];            // Head entry

   always_ff @(posedge clk_i) begin
      if (do_push) mem_q[wr_ptr_q] <= data_i;
   end

   // ------------------------------
   // Pointers and fill count
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at depth
         if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Consumer must check empty before popping
   a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

   a_count_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      count_q <= fifo_cnt_t'(DEPTH));

endmodule

// ==== hdl/uart_tx.sv ====
`include "soc_cfg.svh"

module uart_tx
   import uart_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       cts_i,
   input  logic       empty_i,
   input  uart_byte_t data_i,
   output logic       pop_o,
   output logic       txd_o
);

   localparam bit_timer_t BIT_LAST = bit_timer_t'(`SOC_CLKS_PER_BIT - 1);

   tx_state_t  state_q;
   bit_timer_t timer_q;
   bit_idx_t   idx_q;
   uart_byte_t shift_q;
   logic       txd_q;
   logic       bit_end;

   // CTS only matters between frames
   assign pop_o   = (state_q == TX_IDLE) & ~empty_i & cts_i;
   assign bit_end = (timer_q == BIT_LAST);
   assign txd_o   = txd_q;

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= TX_IDLE;
         timer_q <= '0;
         idx_q   <= '0;
         txd_q   <= 1'b1;
      end else begin
         timer_q <= bit_end ? '0 : timer_q + 1'b1;
         case (state_q)
            TX_IDLE: begin
               timer_q <= '0;
               idx_q   <= '0;
               if (pop_o) begin
                  txd_q   <= 1'b0;   // Start bit
                  state_q <= TX_START;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  txd_q   <= shift_q[0];
                  state_q <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  idx_q <= idx_q + 1'b1;
                  if (idx_q == 3'd7) begin
                     txd_q   <= 1'b1;   // Stop bit
                     state_q <= TX_STOP;
                  end else begin
                     txd_q <= shift_q[1];
                  end
               end
            end
            TX_STOP: if (bit_end) state_q <= TX_IDLE;
            default: state_q <= TX_IDLE;
         endcase
      end
   end

   // Byte latched on pop, then shifted LSB first
   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         shift_q <= data_i;
      end else if (bit_end && state_q == TX_DATA) begin
         shift_q <= shift_q >> 1;
      end
   end

   a_idle_high : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      state_q == TX_IDLE |-> txd_o);

endmodule

// ==== hdl/soc_fpga_wrapper.sv ====
module soc_fpga_wrapper
   import uart_pkg::*;
(
   input  logic clk_i,
   input  logic rst_n_i,        // Board reset
   input  logic pll_locked_i,
   input  logic rxd_i,
   input  logic cts_i,
   output logic txd_o,
   output logic trap_o
);

   logic       rst_n_sync;
   uart_byte_t rx_data;
   logic       rx_valid;
   logic       rx_frame_err;
   uart_byte_t fifo_data;
   logic       fifo_empty;
   logic       fifo_ovf;
   logic       tx_pop;
   logic       trap_q;

   // ------------------------------
   // Clocking and reset
   // ------------------------------
   reset_sync rst_sync (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .pll_locked_i(pll_locked_i),
      .rst_n_o     (rst_n_sync)
   );

   // ------------------------------
   // Console echo path
   // ------------------------------
   uart_rx rx (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_sync),
      .rxd_i      (rxd_i),
      .data_o     (rx_data),
      .valid_o    (rx_valid),
      .frame_err_o(rx_frame_err)
   );

   byte_fifo fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_sync),
      .push_i (rx_valid),
      .data_i (rx_data),
      .pop_i  (tx_pop),
      .data_o (fifo_data),
      .empty_o(fifo_empty),
      .ovf_o  (fifo_ovf)
   );

   uart_tx tx (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_sync),
      .cts_i  (cts_i),
      .empty_i(fifo_empty),
      .data_i (fifo_data),
      .pop_o  (tx_pop),
      .txd_o  (txd_o)
   );

   // Any lost byte sets the trap until reset
   always_ff @(posedge clk_i or negedge rst_n_sync) begin
      if (!rst_n_sync) begin
         trap_q <= 1'b0;
      end else if (rx_frame_err || fifo_ovf) begin
         trap_q <= 1'b1;
      end
   end

   assign trap_o = trap_q;

endmodule

// ==== verif/tb_soc_fpga_wrapper.sv ====
`include "soc_cfg.svh"

module tb_soc_fpga_wrapper
   import uart_pkg::*;
();

   localparam int CPB    = `SOC_CLKS_PER_BIT;
   localparam int DEPTH  = 1 << `SOC_FIFO_DEPTH_LOG2;
   localparam int FRAMES = 1 + 20 + 5 + (DEPTH + 4) + 3;   // Frames sent over all tests
   localparam int LIMIT  = FRAMES * 10 * CPB * 3;

   logic clk_i = 1'b0;
   logic rst_n_i, pll_locked_i, rxd_i, cts_i;
   logic txd_o, trap_o;

   logic [16:0] lfsr_q = 17'd67322;
   uart_byte_t  exp_q[$];                  // Bytes still owed on txd_o
   uart_byte_t  mon_byte;
   logic        trap_exp;
   int unsigned val;
   int          err_cnt, test_err_start, pass_cnt, fail_cnt, got_cnt, got_mark;
   int          cycle_cnt;

   soc_fpga_wrapper DUT (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .pll_locked_i(pll_locked_i),
      .rxd_i       (rxd_i),
      .cts_i       (cts_i),
      .txd_o       (txd_o),
      .trap_o      (trap_o)
   );

   always #5 clk_i = ~clk_i;

   // ------------------------------
   // Random source and checks
   // ------------------------------
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};    // x^17 + x^14 + 1
   endfunction

   task automatic rand_bits(input int n, output int unsigned v);
      v = 0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string name);
      if (got !== exp) begin
         $display("ERROR at %0t: %s expected 0x%02h got 0x%02h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   // ------------------------------
   // Serial driver and model
   // ------------------------------
   task automatic drive_bit(input logic b);
      @(posedge clk_i);
      #1 rxd_i = b;
      repeat (CPB - 1) @(posedge clk_i);
   endtask

   task automatic send_frame(input uart_byte_t b, input logic stop_bit);
      drive_bit(1'b0);                    // Start bit
      for (int k = 0; k < 8; k++) drive_bit(b[k]);
      drive_bit(stop_bit);
      @(posedge clk_i);
      #1 rxd_i = 1'b1;
   endtask

   // FIFO plus the byte held by the transmitter when CTS is high
   task automatic model_push(input uart_byte_t b, input logic good);
      int cap;
      cap = cts_i ? DEPTH + 1 : DEPTH;
      if (!good) trap_exp = 1'b1;
      else if (exp_q.size() >= cap) trap_exp = 1'b1;   // Overflow drop
      else exp_q.push_back(b);
   endtask

   task automatic send_byte(input uart_byte_t b, input logic good);
      int unsigned gap;
      send_frame(b, good);
      model_push(b, good);
      rand_bits(5, gap);
      repeat (gap) @(posedge clk_i);
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(posedge clk_i);
      repeat (2 * 10 * CPB) @(posedge clk_i);    // Room for any stray frame
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      #1 rst_n_i = 1'b0;
      exp_q.delete();
      trap_exp = 1'b0;
      repeat (16) @(posedge clk_i);
      #1 rst_n_i = 1'b1;
      repeat (4) @(posedge clk_i);
      #1;
   endtask

   task automatic end_test(input string name);
      if (err_cnt == test_err_start) begin
         pass_cnt++;
         $display("Test %s: PASS", name);
      end else begin
         fail_cnt++;
         $display("Test %s: FAIL with %0d errors", name, err_cnt - test_err_start);
      end
      test_err_start = err_cnt;
   endtask

   // Decodes txd_o at mid-bit on the falling edge
   always begin
      @(negedge clk_i);
      if (txd_o === 1'b0) begin
         repeat (CPB / 2) @(negedge clk_i);
         check_bit(txd_o, 1'b0, "txd_o start");
         for (int k = 0; k < 8; k++) begin
            repeat (CPB) @(negedge clk_i);
            mon_byte[k] = txd_o;
         end
         repeat (CPB) @(negedge clk_i);
         check_bit(txd_o, 1'b1, "txd_o stop");
         got_cnt++;
         if (exp_q.size() == 0) begin
            $display("Unexpected byte 0x%02h on txd_o while nothing was pending", mon_byte);
            err_cnt++;
         end else begin
            check_byte(mon_byte, exp_q.pop_front(), "echo byte");
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      rst_n_i = 1'b0;
      pll_locked_i = 1'b1;
      rxd_i = 1'b1;
      cts_i = 1'b1;
      trap_exp = 1'b0;
      apply_reset();

      check_bit(txd_o, 1'b1, "txd_o");
      check_bit(trap_o, 1'b0, "trap_o");
      #0 pll_locked_i = 1'b0;              // Lock lost holds the design in reset
      got_mark = got_cnt;
      send_frame(8'h5a, 1'b1);
      repeat (2 * 10 * CPB) @(posedge clk_i);
      if (got_cnt != got_mark) begin
         $display("A byte was echoed while the PLL was not locked");
         err_cnt++;
      end
      #1 pll_locked_i = 1'b1;
      end_test("1 reset and lock");

      apply_reset();
      for (int n = 0; n < 20; n++) begin
         rand_bits(8, val);
         send_byte(uart_byte_t'(val), 1'b1);
      end
      wait_drain();
      check_bit(trap_o, trap_exp, "trap_o");
      end_test("2 random echo");

      for (int t = 0; t < 2; t++) begin
         apply_reset();
         cts_i = 1'b0;
         got_mark = got_cnt;
         for (int n = 0; n < (t == 0 ? 5 : DEPTH + 4); n++) begin
            rand_bits(8, val);
            send_byte(uart_byte_t'(val), 1'b1);
         end
         repeat (2 * 10 * CPB) @(posedge clk_i);
         if (got_cnt != got_mark) begin
            $display("Bytes appeared on txd_o while cts_i was low");
            err_cnt++;
         end
         check_bit(trap_o, trap_exp, "trap_o");
         #1 cts_i = 1'b1;
         wait_drain();
         check_bit(trap_o, trap_exp, "trap_o");
         end_test(t == 0 ? "3 cts hold" : "4 fifo overflow");
      end

      apply_reset();
      rand_bits(8, val);
      send_byte(uart_byte_t'(val), 1'b0);  // Low stop bit
      repeat (2 * CPB) @(posedge clk_i);
      for (int n = 0; n < 2; n++) begin
         rand_bits(8, val);
         send_byte(uart_byte_t'(val), 1'b1);
      end
      wait_drain();
      check_bit(trap_o, trap_exp, "trap_o");
      end_test("5 framing error");

      $display("Totals: %0d tests, %0d passed, %0d failed, %0d errors",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/fifo_pkg.sv
hdl/reset_sync.sv
hdl/uart_rx.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/soc_fpga_wrapper.sv
verif/tb_soc_fpga_wrapper.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_fpga_wrapper
RTL_TOP   ?= soc_fpga_wrapper
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
